//--- sprite_pkg.sv
package sprite_pkg;

    // sprite bitmap memory, two 4-bit pixels per byte
    localparam int SPRITE_NUM = 4;
    localparam int SPRITE_SIZE = 8;
    localparam int SPRITE_ADDR_SIZE = 7;
    localparam int SPRITE_ID_W = $clog2(SPRITE_NUM);

    // screen and framebuffer, address is y*64 + x
    localparam int SCREEN_W = 64;
    localparam int SCREEN_H = 48;
    localparam int FB_ADDR_W = 12;
    localparam int FB_DEPTH = SCREEN_W * SCREEN_H;

    // VGA timing in clocks and lines
    localparam int H_ACTIVE = 64;
    localparam int H_FRONT = 4;
    localparam int H_SYNC = 8;
    localparam int H_BACK = 4;
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_ACTIVE = 48;
    localparam int V_FRONT = 2;
    localparam int V_SYNC = 2;
    localparam int V_BACK = 4;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_CNT_W = $clog2(H_TOTAL);
    localparam int V_CNT_W = $clog2(V_TOTAL);

    // draw request queue
    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_COUNT_W = QUEUE_PTR_W + 1;

    typedef enum logic [7:0] {
        CMD_NOP  = 8'h00,
        CMD_LOAD = 8'h01,
        CMD_DRAW = 8'h02
    } cmd_t;

    // fixed palette, {red, green, blue}
    localparam logic [14:0] PALETTE [16] = '{
        {5'd0, 5'd0, 5'd0},    {5'd0, 5'd0, 5'd20},   {5'd0, 5'd20, 5'd0},   {5'd0, 5'd20, 5'd20},
        {5'd20, 5'd0, 5'd0},   {5'd20, 5'd0, 5'd20},  {5'd20, 5'd20, 5'd0},  {5'd24, 5'd24, 5'd24},
        {5'd12, 5'd12, 5'd12}, {5'd0, 5'd0, 5'd31},   {5'd0, 5'd31, 5'd0},   {5'd0, 5'd31, 5'd31},
        {5'd31, 5'd0, 5'd0},   {5'd31, 5'd0, 5'd31},  {5'd31, 5'd31, 5'd0},  {5'd31, 5'd31, 5'd31}
    };

endpackage

//--- spi_command_rx.sv
`timescale 1ns/1ps

module spi_command_rx (
    input wire logic clock,
    input logic rst_n,
    input logic spi_cs,
    input logic spi_clk,
    input logic spi_mosi,
    input logic [sprite_pkg::QUEUE_COUNT_W-1:0] queue_count,
    output logic spi_miso,
    output logic mem_wr_en,
    output logic [sprite_pkg::SPRITE_ADDR_SIZE-1:0] mem_wr_addr,
    output logic [7:0] mem_wr_data,
    output logic push,
    output logic [sprite_pkg::SPRITE_ID_W-1:0] req_id,
    output logic [7:0] req_x,
    output logic [7:0] req_y
);
    import sprite_pkg::*;

    // two sync flops, the third flop only feeds edge detection
    logic [2:0] sclk_sync;
    logic [2:0] cs_sync;
    logic [1:0] mosi_sync;
    logic cs_active;
    logic cs_start;
    logic sclk_rise;
    logic sclk_fall;

    logic [2:0] bit_cnt;
    logic [6:0] rx_sr;
    logic [7:0] rx_byte;
    logic byte_done;
    logic [7:0] tx_sr;
    logic [5:0] byte_idx;
    logic [5:0] data_off;
    cmd_t cmd_r;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            sclk_sync <= '0;
            cs_sync <= '1;
            mosi_sync <= '0;
        end else begin
            sclk_sync <= {sclk_sync[1:0], spi_clk};
            cs_sync <= {cs_sync[1:0], spi_cs};
            mosi_sync <= {mosi_sync[0], spi_mosi};
        end
    end

    assign cs_active = !cs_sync[1];
    assign cs_start = cs_sync[2] && !cs_sync[1];
    assign sclk_rise = cs_active && sclk_sync[1] && !sclk_sync[2];
    assign sclk_fall = cs_active && !sclk_sync[1] && sclk_sync[2];

    // mosi is stable around the rising edge, so the synced copy lines up
    assign rx_byte = {rx_sr, mosi_sync[1]};
    assign byte_done = sclk_rise && bit_cnt == 3'd7;
    // load data bytes sit at indices 2..33, other indices wrap far above 31
    assign data_off = byte_idx - 6'd2;
    assign spi_miso = tx_sr[7];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            byte_idx <= '0;
            cmd_r <= CMD_NOP;
            tx_sr <= '0;
            mem_wr_en <= 1'b0;
            push <= 1'b0;
        end else begin
            mem_wr_en <= 1'b0;
            push <= 1'b0;
            if (!cs_active) begin
                bit_cnt <= '0;
                byte_idx <= '0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
            // status byte is the queue count taken at byte start
            if (cs_start || byte_done) begin
                tx_sr <= 8'(queue_count);
            end else if (sclk_fall && bit_cnt != 3'd0) begin
                tx_sr <= {tx_sr[6:0], 1'b0};
            end
            if (byte_done) begin
                if (byte_idx != 6'd63) begin
                    byte_idx <= byte_idx + 6'd1;
                end
                if (byte_idx == 6'd0) begin
                    cmd_r <= cmd_t'(rx_byte);
                end else if (cmd_r == CMD_LOAD && data_off < 6'd32) begin
                    mem_wr_en <= 1'b1;
                end else if (cmd_r == CMD_DRAW && byte_idx == 6'd3) begin
                    push <= 1'b1;
                end
            end
        end
    end

    // payload, the id byte serves both load and draw
    always_ff @(posedge clock) begin
        if (sclk_rise) begin
            rx_sr <= rx_byte[6:0];
        end
        if (byte_done) begin
            if (byte_idx == 6'd1) begin
                req_id <= rx_byte[SPRITE_ID_W-1:0];
            end
            if (byte_idx == 6'd2) begin
                req_x <= rx_byte;
            end
            if (byte_idx == 6'd3) begin
                req_y <= rx_byte;
            end
            mem_wr_addr <= {req_id, data_off[4:0]};
            mem_wr_data <= rx_byte;
        end
    end

endmodule

//--- sprite_queue.sv
`timescale 1ns/1ps

module sprite_queue (
    input wire logic clock,
    input logic rst_n,
    input logic push,
    input logic [sprite_pkg::SPRITE_ID_W-1:0] push_id,
    input logic [7:0] push_x,
    input logic [7:0] push_y,
    input logic dequeue,
    output logic empty,
    output logic full,
    output logic [sprite_pkg::QUEUE_COUNT_W-1:0] count,
    output logic [sprite_pkg::SPRITE_ID_W-1:0] head_id,
    output logic [7:0] head_x,
    output logic [7:0] head_y
);
    import sprite_pkg::*;

    logic [SPRITE_ID_W-1:0] id_mem [QUEUE_DEPTH];
    logic [7:0] x_mem [QUEUE_DEPTH];
    logic [7:0] y_mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic do_push;

    assign do_push = push && !full;
    assign empty = count == '0;
    assign full = count == QUEUE_COUNT_W'(QUEUE_DEPTH);

    // show-ahead head
    assign head_id = id_mem[rd_ptr];
    assign head_x = x_mem[rd_ptr];
    assign head_y = y_mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            id_mem[wr_ptr] <= push_id;
            x_mem[wr_ptr] <= push_x;
            y_mem[wr_ptr] <= push_y;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (dequeue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + QUEUE_COUNT_W'(do_push) - QUEUE_COUNT_W'(dequeue);
        end
    end

    // sprite_driver only pops a valid head
    assert property (@(posedge clock) disable iff (!rst_n) dequeue |-> !empty)
        else $error("dequeue while queue empty");

endmodule

//--- sprite_memory.sv
`timescale 1ns/1ps

module sprite_memory (
    input wire logic clock,
    input logic wr_en,
    input logic [sprite_pkg::SPRITE_ADDR_SIZE-1:0] wr_addr,
    input logic [7:0] wr_data,
    input logic [sprite_pkg::SPRITE_ADDR_SIZE-1:0] rd_addr,
    output logic [7:0] rd_data
);
    import sprite_pkg::*;

    // 32 bytes per sprite, high nibble is the left pixel
    logic [7:0] mem [2**SPRITE_ADDR_SIZE];

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data valid one clock after rd_addr
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- sprite_driver.sv
`timescale 1ns/1ps

module sprite_driver (
    input wire logic clock,
    input logic rst_n,
    input logic empty,
    input logic [sprite_pkg::SPRITE_ID_W-1:0] head_id,
    input logic [7:0] head_x,
    input logic [7:0] head_y,
    input logic [7:0] rd_data,
    input logic fb_resetting,
    output logic dequeue,
    output logic [sprite_pkg::SPRITE_ADDR_SIZE-1:0] rd_addr,
    output logic wr_en,
    output logic [sprite_pkg::FB_ADDR_W-1:0] wr_addr,
    output logic [3:0] wr_data
);
    import sprite_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        BLIT
    } state_t;

    state_t state;
    // pix addresses memory, pix_d is the pixel whose byte is on rd_data
    logic [5:0] pix;
    logic [5:0] pix_d;
    logic [SPRITE_ID_W-1:0] id_r;
    logic [7:0] x_r;
    logic [7:0] y_r;
    logic [2:0] col;
    logic [2:0] row;
    logic [8:0] px;
    logic [8:0] py;
    logic [3:0] index;
    logic visible;

    assign dequeue = state == IDLE && !empty && !fb_resetting;
    assign rd_addr = {id_r, pix[5:1]};

    assign col = pix_d[2:0];
    assign row = pix_d[5:3];
    assign index = col[0] ? rd_data[3:0] : rd_data[7:4];
    // 9 bits so positions past 255 never wrap back on screen
    assign px = {1'b0, x_r} + {6'd0, col};
    assign py = {1'b0, y_r} + {6'd0, row};
    assign visible = index != 4'd0 && px < 9'(SCREEN_W) && py < 9'(SCREEN_H);

    // pixels landing during a clear are dropped
    assign wr_en = state == BLIT && visible && !fb_resetting;
    assign wr_addr = {py[5:0], px[5:0]};
    assign wr_data = index;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            pix <= '0;
            pix_d <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (dequeue) begin
                        state <= FETCH;
                        pix <= '0;
                    end
                end
                FETCH: begin
                    state <= BLIT;
                    pix <= pix + 6'd1;
                    pix_d <= pix;
                end
                BLIT: begin
                    pix <= pix + 6'd1;
                    pix_d <= pix;
                    if (pix_d == 6'(SPRITE_SIZE * SPRITE_SIZE - 1)) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request is latched as it leaves the queue
    always_ff @(posedge clock) begin
        if (dequeue) begin
            id_r <= head_id;
            x_r <= head_x;
            y_r <= head_y;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        wr_en |-> wr_addr < FB_ADDR_W'(FB_DEPTH))
        else $error("framebuffer write outside screen");

endmodule

//--- framebuffer_master.sv
`timescale 1ns/1ps

module framebuffer_master (
    input wire logic clock,
    input logic rst_n,
    input logic vsync,
    input logic wr_en,
    input logic [sprite_pkg::FB_ADDR_W-1:0] wr_addr,
    input logic [3:0] wr_data,
    input logic [sprite_pkg::FB_ADDR_W-1:0] scan_addr,
    output logic [3:0] scan_data,
    output logic fb_resetting
);
    import sprite_pkg::*;

    logic [3:0] bank0 [FB_DEPTH];
    logic [3:0] bank1 [FB_DEPTH];
    // front_sel high shows bank1, the other bank is written
    logic front_sel;
    logic sel_d;
    logic vsync_d;
    logic vsync_fall;
    logic [FB_ADDR_W-1:0] clr_addr;
    logic bank_we;
    logic [FB_ADDR_W-1:0] bank_addr;
    logic [3:0] bank_data;
    logic [3:0] rd0;
    logic [3:0] rd1;

    assign vsync_fall = vsync_d && !vsync;

    // clear has the back bank port
    assign bank_we = fb_resetting || wr_en;
    assign bank_addr = fb_resetting ? clr_addr : wr_addr;
    assign bank_data = fb_resetting ? 4'd0 : wr_data;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            vsync_d <= 1'b1;
            front_sel <= 1'b0;
            sel_d <= 1'b0;
            fb_resetting <= 1'b1;
            clr_addr <= '0;
        end else begin
            vsync_d <= vsync;
            sel_d <= front_sel;
            if (vsync_fall) begin
                front_sel <= !front_sel;
                fb_resetting <= 1'b1;
                clr_addr <= '0;
            end else if (fb_resetting) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == FB_ADDR_W'(FB_DEPTH - 1)) begin
                    fb_resetting <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (bank_we && front_sel) begin
            bank0[bank_addr] <= bank_data;
        end
        rd0 <= bank0[scan_addr];
    end

    always_ff @(posedge clock) begin
        if (bank_we && !front_sel) begin
            bank1[bank_addr] <= bank_data;
        end
        rd1 <= bank1[scan_addr];
    end

    assign scan_data = sel_d ? rd1 : rd0;

    // sprite_driver must stay off the port during a clear
    assert property (@(posedge clock) disable iff (!rst_n) fb_resetting |-> !wr_en)
        else $error("sprite write during framebuffer clear");

endmodule

//--- screen_driver.sv
`timescale 1ns/1ps

module screen_driver (
    input wire logic clock,
    input logic rst_n,
    input logic [3:0] scan_data,
    output logic [sprite_pkg::FB_ADDR_W-1:0] scan_addr,
    output logic vga_hsync,
    output logic vga_vsync,
    output logic [4:0] vga_red,
    output logic [4:0] vga_green,
    output logic [4:0] vga_blue
);
    import sprite_pkg::*;

    logic [H_CNT_W-1:0] h_cnt;
    logic [V_CNT_W-1:0] v_cnt;
    logic active;
    logic active_d;
    logic hsync_area;
    logic vsync_area;
    logic [14:0] colour;

    assign active = h_cnt < H_CNT_W'(H_ACTIVE) && v_cnt < V_CNT_W'(V_ACTIVE);
    assign hsync_area = h_cnt >= H_CNT_W'(H_ACTIVE + H_FRONT)
        && h_cnt < H_CNT_W'(H_ACTIVE + H_FRONT + H_SYNC);
    assign vsync_area = v_cnt >= V_CNT_W'(V_ACTIVE + V_FRONT)
        && v_cnt < V_CNT_W'(V_ACTIVE + V_FRONT + V_SYNC);

    // y*64 + x, parked at zero during blanking
    assign scan_addr = active ? {v_cnt, h_cnt[5:0]} : '0;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            active_d <= 1'b0;
        end else begin
            if (h_cnt == H_CNT_W'(H_TOTAL - 1)) begin
                h_cnt <= '0;
                if (v_cnt == V_CNT_W'(V_TOTAL - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
            // delayed one clock to line up with scan_data
            vga_hsync <= !hsync_area;
            vga_vsync <= !vsync_area;
            active_d <= active;
        end
    end

    assign colour = PALETTE[scan_data];
    assign vga_red = active_d ? colour[14:10] : 5'd0;
    assign vga_green = active_d ? colour[9:5] : 5'd0;
    assign vga_blue = active_d ? colour[4:0] : 5'd0;

endmodule

//--- sprite_display_top.sv
`timescale 1ns/1ps

module sprite_display_top (
    input wire logic clock,
    input logic rst_n,
    input logic spi_cs,
    input logic spi_clk,
    input logic spi_mosi,
    output logic spi_miso,
    output logic vga_hsync,
    output logic vga_vsync,
    output logic [4:0] vga_red,
    output logic [4:0] vga_green,
    output logic [4:0] vga_blue
);
    import sprite_pkg::*;

    // SPI side into sprite memory and queue
    logic mem_wr_en;
    logic [SPRITE_ADDR_SIZE-1:0] mem_wr_addr;
    logic [7:0] mem_wr_data;
    logic push;
    logic [SPRITE_ID_W-1:0] req_id;
    logic [7:0] req_x;
    logic [7:0] req_y;
    logic [QUEUE_COUNT_W-1:0] queue_count;

    // queue head into the blitter
    logic queue_empty;
    logic dequeue;
    logic [SPRITE_ID_W-1:0] head_id;
    logic [7:0] head_x;
    logic [7:0] head_y;
    logic [SPRITE_ADDR_SIZE-1:0] spr_rd_addr;
    logic [7:0] spr_rd_data;

    // framebuffer ports
    logic fb_wr_en;
    logic [FB_ADDR_W-1:0] fb_wr_addr;
    logic [3:0] fb_wr_data;
    logic fb_resetting;
    logic [FB_ADDR_W-1:0] scan_addr;
    logic [3:0] scan_data;

    spi_command_rx spi_rx (
        .clock,
        .rst_n,
        .spi_cs,
        .spi_clk,
        .spi_mosi,
        .queue_count,
        .spi_miso,
        .mem_wr_en,
        .mem_wr_addr,
        .mem_wr_data,
        .push,
        .req_id,
        .req_x,
        .req_y
    );

    sprite_queue queue (
        .clock,
        .rst_n,
        .push,
        .push_id(req_id),
        .push_x(req_x),
        .push_y(req_y),
        .dequeue,
        .empty(queue_empty),
        .full(),
        .count(queue_count),
        .head_id,
        .head_x,
        .head_y
    );

    sprite_memory spr_mem (
        .clock,
        .wr_en(mem_wr_en),
        .wr_addr(mem_wr_addr),
        .wr_data(mem_wr_data),
        .rd_addr(spr_rd_addr),
        .rd_data(spr_rd_data)
    );

    sprite_driver spr_driver (
        .clock,
        .rst_n,
        .empty(queue_empty),
        .head_id,
        .head_x,
        .head_y,
        .rd_data(spr_rd_data),
        .fb_resetting,
        .dequeue,
        .rd_addr(spr_rd_addr),
        .wr_en(fb_wr_en),
        .wr_addr(fb_wr_addr),
        .wr_data(fb_wr_data)
    );

    // the VGA frame drives the buffer swap
    framebuffer_master fb_master (
        .clock,
        .rst_n,
        .vsync(vga_vsync),
        .wr_en(fb_wr_en),
        .wr_addr(fb_wr_addr),
        .wr_data(fb_wr_data),
        .scan_addr,
        .scan_data,
        .fb_resetting
    );

    screen_driver sd (
        .clock,
        .rst_n,
        .scan_data,
        .scan_addr,
        .vga_hsync,
        .vga_vsync,
        .vga_red,
        .vga_green,
        .vga_blue
    );

endmodule

//--- tb_sprite_display.sv
`timescale 1ns/1ps

module tb_sprite_display;
    import sprite_pkg::*;

    // VGA frame as seen on the pins
    localparam int LINE_CLKS = 80;
    localparam int FRAME_LINES = 56;
    localparam int FRAME_CLKS = FRAME_LINES * LINE_CLKS;
    // vsync is first seen low two counts into line 50
    localparam int SWAP_TO_FRAME = (FRAME_LINES - 50) * LINE_CLKS - 2;
    localparam int TIMEOUT_CYCLES = 12 * FRAME_CLKS;
    localparam int MAX_LISTED = 10;

    logic clock = 1'b0;
    logic rst_n;
    logic spi_cs;
    logic spi_clk;
    logic spi_mosi;
    logic spi_miso;
    logic vga_hsync;
    logic vga_vsync;
    logic [4:0] vga_red;
    logic [4:0] vga_green;
    logic [4:0] vga_blue;
    logic [14:0] colour;

    // reference model state
    logic [3:0] spr_model [4][64];
    logic [3:0] ref_fb [3072];
    logic [14:0] cap_fb [3072];
    logic [7:0] load_buf [32];
    logic [31:0] lcg_state = 32'd59;
    int error_count = 0;
    int test_count = 0;
    int failed_tests = 0;
    int cycle_count = 0;

    sprite_display_top UUT (
        .clock,
        .rst_n,
        .spi_cs,
        .spi_clk,
        .spi_mosi,
        .spi_miso,
        .vga_hsync,
        .vga_vsync,
        .vga_red,
        .vga_green,
        .vga_blue
    );

    assign colour = {vga_red, vga_green, vga_blue};

    always #5 clock = !clock;

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    task automatic report_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        error_count++;
        $display("ERR t=%0t %s: expected %0d, got %0d", $time, what, expected, actual);
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        test_count++;
        if (error_count == errs_at_start) begin
            $display("test %0d %s: passed", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed, %0d mismatches", test_count, name,
                     error_count - errs_at_start);
        end
    endtask

    // mode 0, data set while spi_clk is low, eight clocks per bit
    task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            spi_mosi <= tx[i];
            repeat (4) @(posedge clock);
            rx[i] = spi_miso;
            spi_clk <= 1'b1;
            repeat (4) @(posedge clock);
            spi_clk <= 1'b0;
        end
    endtask

    task automatic begin_command;
        spi_cs <= 1'b0;
        repeat (4) @(posedge clock);
    endtask

    task automatic end_command;
        repeat (4) @(posedge clock);
        spi_cs <= 1'b1;
        repeat (6) @(posedge clock);
    endtask

    task automatic send_load(input logic [1:0] id);
        logic [7:0] rx;
        begin_command();
        spi_byte(CMD_LOAD, rx);
        spi_byte({6'd0, id}, rx);
        for (int i = 0; i < 32; i++) begin
            spi_byte(load_buf[i], rx);
        end
        end_command();
    endtask

    task automatic send_draw(input logic [1:0] id, input logic [7:0] x, input logic [7:0] y);
        logic [7:0] rx;
        begin_command();
        spi_byte(CMD_DRAW, rx);
        spi_byte({6'd0, id}, rx);
        spi_byte(x, rx);
        spi_byte(y, rx);
        end_command();
    endtask

    task automatic send_nop(output logic [7:0] status);
        begin_command();
        spi_byte(CMD_NOP, status);
        end_command();
    endtask

    task automatic model_clear;
        for (int a = 0; a < 3072; a++) begin
            ref_fb[a] = 4'd0;
        end
    endtask

    // index 0 is transparent, anything past the screen edge is dropped
    task automatic model_draw(input int id, input int x, input int y);
        int px;
        int py;
        logic [3:0] idx;
        for (int row = 0; row < 8; row++) begin
            for (int col = 0; col < 8; col++) begin
                idx = spr_model[id][row * 8 + col];
                px = x + col;
                py = y + row;
                if (idx != 4'd0 && px < 64 && py < 48) begin
                    ref_fb[py * 64 + px] = idx;
                end
            end
        end
    endtask

    task automatic load_sprites;
        logic [7:0] b;
        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < 32; i++) begin
                b = lcg_byte();
                // sprite 3 has a see-through right pixel in every pair
                if (s == 3) begin
                    b[3:0] = 4'd0;
                end
                load_buf[i] = b;
                spr_model[s][2 * i] = b[7:4];
                spr_model[s][2 * i + 1] = b[3:0];
            end
            send_load(2'(s));
        end
    endtask

    task automatic wait_swap;
        logic prev_vs;
        prev_vs = vga_vsync;
        @(posedge clock);
        while (!(prev_vs === 1'b1 && vga_vsync === 1'b0)) begin
            prev_vs = vga_vsync;
            @(posedge clock);
        end
    endtask

    // called right after wait_swap, pixel x shows one count after h = x
    task automatic capture_frame;
        repeat (SWAP_TO_FRAME) @(posedge clock);
        for (int y = 0; y < 48; y++) begin
            for (int h = 0; h < LINE_CLKS; h++) begin
                @(posedge clock);
                if (h >= 1 && h <= 64) begin
                    cap_fb[y * 64 + h - 1] = colour;
                end else if (colour !== 15'd0) begin
                    error_count++;
                    $display("ERR t=%0t blanking on line %0d count %0d: expected 0, got %h",
                             $time, y, h, colour);
                end
            end
        end
    endtask

    task automatic compare_frame;
        int bad;
        logic [14:0] expected;
        bad = 0;
        for (int a = 0; a < 3072; a++) begin
            expected = PALETTE[ref_fb[a]];
            if (cap_fb[a] !== expected) begin
                bad++;
                error_count++;
                if (bad <= MAX_LISTED) begin
                    $display("ERR t=%0t pixel (%0d,%0d): expected %h, got %h",
                             $time, a % 64, a / 64, expected, cap_fb[a]);
                end
            end
        end
        if (bad > MAX_LISTED) begin
            $display("%0d more pixel mismatches not listed", bad - MAX_LISTED);
        end
    endtask

    task automatic check_reset_and_timing;
        int errs;
        int clk_cnt;
        int hs_falls;
        int last_fall;
        logic prev_hs;
        logic prev_vs;
        logic done;
        errs = error_count;
        @(posedge clock);
        if (vga_hsync !== 1'b1 || vga_vsync !== 1'b1) begin
            report_value("syncs after reset", 3, {vga_hsync, vga_vsync});
        end
        if (colour !== 15'd0) begin
            report_value("colour after reset", 0, colour);
        end
        if (spi_miso !== 1'b0) begin
            report_value("miso after reset", 0, spi_miso);
        end
        wait_swap();
        clk_cnt = 0;
        hs_falls = 0;
        last_fall = -1;
        prev_hs = vga_hsync;
        prev_vs = vga_vsync;
        done = 1'b0;
        while (!done) begin
            @(posedge clock);
            clk_cnt++;
            if (prev_hs === 1'b1 && vga_hsync === 1'b0) begin
                if (last_fall >= 0 && clk_cnt - last_fall != LINE_CLKS) begin
                    report_value("hsync period", LINE_CLKS, clk_cnt - last_fall);
                end
                last_fall = clk_cnt;
                hs_falls++;
            end
            if ((vga_hsync !== 1'b1 || vga_vsync !== 1'b1) && colour !== 15'd0) begin
                report_value("colour during sync", 0, colour);
            end
            if (prev_vs === 1'b1 && vga_vsync === 1'b0) begin
                done = 1'b1;
            end
            prev_hs = vga_hsync;
            prev_vs = vga_vsync;
        end
        if (clk_cnt != FRAME_CLKS) begin
            report_value("vsync period", FRAME_CLKS, clk_cnt);
        end
        if (hs_falls != FRAME_LINES) begin
            report_value("hsync pulses per frame", FRAME_LINES, hs_falls);
        end
        end_test("reset and sync timing", errs);
    endtask

    task automatic load_and_draw;
        int errs;
        errs = error_count;
        wait_swap();
        send_draw(2'd1, 8'd28, 8'd20);
        model_clear();
        model_draw(1, 28, 20);
        wait_swap();
        capture_frame();
        compare_frame();
        end_test("load and draw", errs);
    endtask

    task automatic overlap_transparency;
        int errs;
        errs = error_count;
        wait_swap();
        send_draw(2'd0, 8'd20, 8'd20);
        send_draw(2'd3, 8'd23, 8'd22);
        model_clear();
        model_draw(0, 20, 20);
        model_draw(3, 23, 22);
        wait_swap();
        capture_frame();
        compare_frame();
        end_test("transparency and order", errs);
    endtask

    task automatic clip_at_edges;
        int errs;
        errs = error_count;
        wait_swap();
        send_draw(2'd2, 8'd60, 8'd44);
        send_draw(2'd0, 8'd200, 8'd10);
        send_draw(2'd1, 8'd10, 8'd100);
        model_clear();
        model_draw(2, 60, 44);
        model_draw(0, 200, 10);
        model_draw(1, 10, 100);
        wait_swap();
        capture_frame();
        compare_frame();
        end_test("clipping", errs);
    endtask

    // draws pile up in the queue while the back buffer clears
    task automatic overflow_queue;
        int errs;
        logic [7:0] status;
        errs = error_count;
        wait_swap();
        model_clear();
        // first sprite covers address 0 where blanking scans park
        for (int i = 0; i < 10; i++) begin
            send_draw(2'(i % 4), 8'((i % 5) * 12), 8'((i / 5) * 16));
            if (i < 8) begin
                model_draw(i % 4, (i % 5) * 12, (i / 5) * 16);
            end
        end
        send_nop(status);
        if (status !== 8'd8) begin
            report_value("queue status byte", 8, status);
        end
        wait_swap();
        capture_frame();
        compare_frame();
        end_test("queue status and overflow", errs);
    endtask

    task automatic frame_clear;
        int errs;
        errs = error_count;
        model_clear();
        wait_swap();
        capture_frame();
        compare_frame();
        end_test("per-frame clear", errs);
    endtask

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d clocks", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        spi_cs = 1'b1;
        spi_clk = 1'b0;
        spi_mosi = 1'b0;
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
        // sprites load while the first frames are timed
        fork
            check_reset_and_timing();
            load_sprites();
        join
        load_and_draw();
        overlap_transparency();
        clip_at_edges();
        overflow_queue();
        frame_clear();
        $display("tests %0d, failed %0d, mismatches %0d", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- sprite_display.f
sprite_pkg.sv
spi_command_rx.sv
sprite_queue.sv
sprite_memory.sv
sprite_driver.sv
framebuffer_master.sv
screen_driver.sv
sprite_display_top.sv
tb_sprite_display.sv

//--- Bender.yml
package:
  name: sprite_display

sources:
  - sprite_pkg.sv
  - spi_command_rx.sv
  - sprite_queue.sv
  - sprite_memory.sv
  - sprite_driver.sv
  - framebuffer_master.sv
  - screen_driver.sv
  - sprite_display_top.sv
  - target: test
    files:
      - tb_sprite_display.sv
